//--- hdl/io_pkg.sv
package io_pkg;

    typedef logic [7:0]  addr_t;        // Local byte address
    typedef logic [31:0] data_t;        // Bus data word
    typedef logic [1:0]  resp_t;        // Bus response code
    typedef logic [5:0]  led_t;
    typedef logic [2:0]  button_t;
    typedef logic [1:0]  switch_t;
    typedef logic [23:0] tone_period_t; // Half-period in clock cycles

    // One machine per channel, read and write
    typedef enum logic {
        bus_idle,
        bus_respond
    } bus_state_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    localparam addr_t ADDR_LEDS          = 8'h00;
    localparam addr_t ADDR_TONE_CTRL     = 8'h04; // Bit 0 enables the tone
    localparam addr_t ADDR_TONE_PERIOD   = 8'h08;
    localparam addr_t ADDR_CYCLE_COUNT   = 8'h10; // Any write clears
    localparam addr_t ADDR_BUTTON_STATUS = 8'h14; // Bit 0 is empty
    localparam addr_t ADDR_BUTTON_DATA   = 8'h18; // Read pops one event
    localparam addr_t ADDR_SWITCHES      = 8'h1C;

    localparam int BUTTON_FIFO_DEPTH  = 8;
    localparam int BUTTON_PTR_WIDTH   = $clog2(BUTTON_FIFO_DEPTH);
    localparam int BUTTON_COUNT_WIDTH = $clog2(BUTTON_FIFO_DEPTH + 1);

endpackage

//--- hdl/tone_generator.sv
`timescale 1ns/100ps

module tone_generator (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  io_pkg::tone_period_t period,
    output logic                 square_out
);
    import io_pkg::*;

    tone_period_t count;
    logic         level;
    logic         running;

    assign running    = enable && (period != '0);
    assign square_out = level;

    // Level flips once every period cycles
    always_ff @(posedge clk) begin
        if (reset || !running) begin
            count <= '0;
            level <= 1'b0; // Idle low
        end else if (count >= period - 1'b1) begin
            count <= '0;
            level <= ~level;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- hdl/button_fifo.sv
`timescale 1ns/100ps

module button_fifo (
    input  logic            clk,
    input  logic            reset,
    input  io_pkg::button_t buttons,
    input  logic            pop,
    output io_pkg::button_t data,
    output logic            empty
);
    import io_pkg::*;

    button_t                       mem [BUTTON_FIFO_DEPTH];
    button_t                       sync_meta;
    button_t                       sync_out;
    button_t                       sync_prev;
    logic [BUTTON_PTR_WIDTH-1:0]   wr_ptr;
    logic [BUTTON_PTR_WIDTH-1:0]   rd_ptr;
    logic [BUTTON_COUNT_WIDTH-1:0] count;
    logic                          full;
    logic                          change;
    logic                          do_push;
    logic                          do_pop;

    function automatic logic [BUTTON_PTR_WIDTH-1:0] next_ptr(
        input logic [BUTTON_PTR_WIDTH-1:0] ptr
    );
        if (ptr == BUTTON_PTR_WIDTH'(BUTTON_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // New nonzero pattern after the second flop
    assign change  = (sync_out != sync_prev) && (sync_out != '0);
    assign full    = (count == BUTTON_COUNT_WIDTH'(BUTTON_FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = change && !full; // Events lost when full
    assign do_pop  = pop && !empty;
    assign data    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_meta <= '0;
            sync_out  <= '0;
            sync_prev <= '0;
        end else begin
            sync_meta <= buttons;
            sync_out  <= sync_meta;
            sync_prev <= sync_out;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= sync_out;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

endmodule

//--- hdl/io_regs.sv
`timescale 1ns/100ps

module io_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  io_pkg::addr_t        awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  io_pkg::data_t        wdata,
    input  logic [3:0]           wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output io_pkg::resp_t        bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  io_pkg::addr_t        araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output io_pkg::data_t        rdata,
    output io_pkg::resp_t        rresp,
    output logic                 rvalid,
    input  logic                 rready,
    input  io_pkg::switch_t      switches,
    input  io_pkg::button_t      button_data,
    input  logic                 button_empty,
    output logic                 button_pop,
    output io_pkg::led_t         leds,
    output logic                 tone_enable,
    output io_pkg::tone_period_t tone_period
);
    import io_pkg::*;

    bus_state_t w_state;
    bus_state_t r_state;
    data_t      cycle_count;
    data_t      read_word;
    resp_t      read_resp;
    logic       write_fire;
    logic       read_fire;
    logic       clear_count;

    // Address and data are taken together, only with no response pending
    assign write_fire  = awvalid && wvalid && (w_state == bus_idle);
    assign awready     = write_fire;
    assign wready      = write_fire;
    assign bvalid      = (w_state == bus_respond);
    assign read_fire   = arvalid && arready;
    assign rvalid      = (r_state == bus_respond);
    assign clear_count = write_fire && (awaddr == ADDR_CYCLE_COUNT);
    assign button_pop  = read_fire && (araddr == ADDR_BUTTON_DATA) && !button_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            w_state <= bus_idle;
        end else begin
            case (w_state)
                bus_idle: begin
                    if (write_fire) begin
                        w_state <= bus_respond;
                    end
                end
                bus_respond: begin
                    if (bready) begin
                        w_state <= bus_idle;
                    end
                end
                default: w_state <= bus_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (write_fire) begin
            case (awaddr)
                ADDR_LEDS, ADDR_TONE_CTRL, ADDR_TONE_PERIOD, ADDR_CYCLE_COUNT: begin
                    bresp <= RESP_OKAY;
                end
                default: bresp <= RESP_SLVERR; // Unmapped or read-only
            endcase
        end
    end

    // Whole-word writes, strobes not used
    always_ff @(posedge clk) begin
        if (reset) begin
            leds        <= '0;
            tone_enable <= 1'b0;
            tone_period <= '0;
        end else if (write_fire) begin
            case (awaddr)
                ADDR_LEDS:        leds        <= led_t'(wdata);
                ADDR_TONE_CTRL:   tone_enable <= wdata[0];
                ADDR_TONE_PERIOD: tone_period <= tone_period_t'(wdata);
                default:          ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear_count) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_comb begin
        read_word = '0;
        read_resp = RESP_OKAY;
        case (araddr)
            ADDR_LEDS:          read_word = data_t'(leds);
            ADDR_TONE_CTRL:     read_word = data_t'(tone_enable);
            ADDR_TONE_PERIOD:   read_word = data_t'(tone_period);
            ADDR_CYCLE_COUNT:   read_word = cycle_count;
            ADDR_BUTTON_STATUS: read_word = data_t'(button_empty);
            ADDR_BUTTON_DATA:   read_word = data_t'(button_data); // FIFO head
            ADDR_SWITCHES:      read_word = data_t'(switches);
            default:            read_resp = RESP_SLVERR;
        endcase
    end

    // arready held low through reset, high whenever no read is pending
    always_ff @(posedge clk) begin
        if (reset) begin
            r_state <= bus_idle;
            arready <= 1'b0;
        end else begin
            case (r_state)
                bus_idle: begin
                    if (read_fire) begin
                        r_state <= bus_respond;
                        arready <= 1'b0;
                    end else begin
                        arready <= 1'b1;
                    end
                end
                bus_respond: begin
                    if (rready) begin
                        r_state <= bus_idle;
                        arready <= 1'b1;
                    end
                end
                default: r_state <= bus_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (read_fire) begin
            rdata <= read_word; // Held until rready
            rresp <= read_resp;
        end
    end

endmodule

//--- hdl/io_top.sv
`timescale 1ns/100ps

module io_top (
    input  logic            clk,
    input  logic            reset,
    input  io_pkg::addr_t   awaddr,
    input  logic            awvalid,
    output logic            awready,
    input  io_pkg::data_t   wdata,
    input  logic [3:0]      wstrb,
    input  logic            wvalid,
    output logic            wready,
    output io_pkg::resp_t   bresp,
    output logic            bvalid,
    input  logic            bready,
    input  io_pkg::addr_t   araddr,
    input  logic            arvalid,
    output logic            arready,
    output io_pkg::data_t   rdata,
    output io_pkg::resp_t   rresp,
    output logic            rvalid,
    input  logic            rready,
    input  io_pkg::button_t buttons,
    input  io_pkg::switch_t switches,
    output io_pkg::led_t    leds,
    output logic            pwm
);
    import io_pkg::*;

    button_t      button_data;
    logic         button_empty;
    logic         button_pop;
    logic         tone_enable;
    tone_period_t tone_period;

    io_regs regs (
        .clk(clk),
        .reset(reset),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .switches(switches),
        .button_data(button_data),   // From gpio_buttons
        .button_empty(button_empty), // From gpio_buttons
        .button_pop(button_pop),     // To gpio_buttons
        .leds(leds),
        .tone_enable(tone_enable),   // To audio_tone
        .tone_period(tone_period)    // To audio_tone
    );

    button_fifo gpio_buttons (
        .clk(clk),
        .reset(reset),
        .buttons(buttons),
        .pop(button_pop),
        .data(button_data),
        .empty(button_empty)
    );

    tone_generator audio_tone (
        .clk(clk),
        .reset(reset),
        .enable(tone_enable),
        .period(tone_period),
        .square_out(pwm)
    );

endmodule

//--- tests/io_assertions.sv
`timescale 1ns/100ps

module io_assertions (
    input logic          clk,
    input logic          reset,
    input logic          bvalid,
    input logic          bready,
    input logic          rvalid,
    input logic          rready,
    input io_pkg::data_t rdata,
    input io_pkg::led_t  leds
);

    bvalid_held: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // Read data frozen while the master stalls
    rdata_held: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

    leds_cleared: assert property (@(posedge clk) $fell(reset) |-> leds == '0)
        else $error("leds not zero in the first cycle after reset");

endmodule

bind io_regs io_assertions bus_rules (
    .clk(clk),
    .reset(reset),
    .bvalid(bvalid),
    .bready(bready),
    .rvalid(rvalid),
    .rready(rready),
    .rdata(rdata),
    .leds(leds)
);

//--- tests/io_checker.sv
`timescale 1ns/100ps

module io_checker (
    input logic          clk,
    input logic          reset,
    input io_pkg::addr_t awaddr,
    input logic          awvalid,
    input logic          awready,
    input logic          wready,
    input io_pkg::data_t wdata,
    input io_pkg::resp_t bresp,
    input logic          bvalid,
    input logic          bready,
    input io_pkg::addr_t araddr,
    input logic          arvalid,
    input logic          arready,
    input io_pkg::data_t rdata,
    input io_pkg::resp_t rresp,
    input logic          rvalid,
    input logic          rready,
    input io_pkg::led_t  leds,
    input logic          pwm
);
    import io_pkg::*;

    string read_name_q[$];
    data_t read_data_q[$];
    resp_t read_resp_q[$];
    bit    read_count_q[$];  // Expected value comes from the cycle count
    string write_name_q[$];
    resp_t write_resp_q[$];
    int    value_errors = 0;
    int    other_errors = 0;
    int    cycle = 0;
    int    clear_cycle = 0;
    data_t count_expect = '0;
    addr_t last_waddr = '0;
    led_t  led_expect = '0;
    logic  write_taken = 1'b0;
    logic  read_taken = 1'b0;
    string tone_name = "";
    int    tone_expect = 0;
    int    tone_mode = 0;    // 0 idle, 1 wait for rise, 2 high run, 3 must stay low
    int    tone_run = 0;
    int    tone_timer = 0;
    logic  pwm_prev = 1'b0;

    function automatic void expect_read(string name, data_t value, resp_t resp, bit use_count);
        read_name_q.push_back(name);
        read_data_q.push_back(value);
        read_resp_q.push_back(resp);
        read_count_q.push_back(use_count);
    endfunction

    function automatic void expect_write(string name, resp_t resp);
        write_name_q.push_back(name);
        write_resp_q.push_back(resp);
    endfunction

    function automatic void start_tone(string name, int run);
        tone_name   = name;
        tone_expect = run;
        tone_timer  = 0;
        tone_mode   = (run == 0) ? 3 : 1;
    endfunction

    function automatic void compare_value(string name, string what, data_t expected,
                                          data_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s (%s): expected %h, actual %h", name, what, expected, actual);
        end
    endfunction

    always @(posedge clk) begin
        string name;
        data_t expected;
        bit    use_count;
        if (!reset) begin
            if (awready !== wready) begin
                other_errors++;
                $display("awready and wready were not raised in the same cycle");
            end
            if (write_taken && !bvalid) begin
                other_errors++;
                $display("bvalid did not rise one cycle after the write handshake");
            end
            if (read_taken && !rvalid) begin
                other_errors++;
                $display("rvalid did not rise one cycle after the read handshake");
            end
            if (awvalid && awready) begin
                last_waddr = awaddr;
                if (awaddr == ADDR_LEDS) begin
                    led_expect = led_t'(wdata); // Low six bits
                end
                if (awaddr == ADDR_CYCLE_COUNT) begin
                    clear_cycle = cycle;
                end
            end
            if (awready && bvalid) begin
                other_errors++;
                $display("A write was accepted while a write response was still pending");
            end
            if (bvalid && bready) begin
                if (write_name_q.size() == 0) begin
                    other_errors++;
                    $display("A write response arrived with no write outstanding");
                end else begin
                    name = write_name_q.pop_front();
                    compare_value(name, "bresp", data_t'(write_resp_q.pop_front()), data_t'(bresp));
                    if (last_waddr == ADDR_LEDS) begin
                        compare_value(name, "leds", data_t'(led_expect), data_t'(leds));
                    end
                end
            end
            if (arvalid && arready && araddr == ADDR_CYCLE_COUNT) begin
                count_expect = data_t'(cycle - clear_cycle - 1); // Zero one cycle after clear
            end
            if (rvalid && rready) begin
                if (read_name_q.size() == 0) begin
                    other_errors++;
                    $display("A read response arrived with no read outstanding");
                end else begin
                    name      = read_name_q.pop_front();
                    expected  = read_data_q.pop_front();
                    use_count = read_count_q.pop_front();
                    if (use_count) begin
                        expected = count_expect;
                    end
                    compare_value(name, "rdata", expected, rdata);
                    compare_value(name, "rresp", data_t'(read_resp_q.pop_front()), data_t'(rresp));
                end
            end
            write_taken = awvalid && awready;
            read_taken  = arvalid && arready;
            cycle++;
        end
    end

    // Length of one high run of pwm, or a quiet window
    always @(posedge clk) begin
        case (tone_mode)
            1: begin
                if (pwm && !pwm_prev) begin
                    tone_mode = 2;
                    tone_run  = 1;
                end
            end
            2: begin
                if (pwm) begin
                    tone_run++;
                end else begin
                    compare_value(tone_name, "pwm high run", data_t'(tone_expect),
                                  data_t'(tone_run));
                    tone_mode = 0;
                end
            end
            3: begin
                if (pwm) begin
                    other_errors++;
                    $display("pwm went high while the tone was off in %s", tone_name);
                    tone_mode = 0;
                end else if (tone_timer == 40) begin
                    tone_mode = 0;
                end
            end
            default: ;
        endcase
        tone_timer++;
        if (tone_mode != 0 && tone_timer > 200) begin
            other_errors++;
            $display("No complete pwm high run within 200 cycles in %s", tone_name);
            tone_mode = 0;
        end
        pwm_prev = pwm;
    end

endmodule

//--- tests/io_top_tb.sv
`timescale 1ns/100ps

module io_top_tb;
    import io_pkg::*;

    logic    clk = 1'b0;
    logic    reset;
    addr_t   awaddr;
    logic    awvalid;
    logic    awready;
    data_t   wdata;
    logic [3:0] wstrb;
    logic    wvalid;
    logic    wready;
    resp_t   bresp;
    logic    bvalid;
    logic    bready;
    addr_t   araddr;
    logic    arvalid;
    logic    arready;
    data_t   rdata;
    resp_t   rresp;
    logic    rvalid;
    logic    rready;
    button_t buttons;
    switch_t switches;
    led_t    leds;
    logic    pwm;
    int      run_errors = 0;

    io_top UUT (.*);

    io_checker scoreboard (.*);

    always #2 clk = ~clk;

    function automatic void report_timeout(string what);
        run_errors++;
        $display("Timed out waiting for %s", what);
    endfunction

    task automatic do_write(addr_t addr, data_t data);
        int stall;
        int t;
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!awready && t < 100);
        if (!awready) begin
            report_timeout("the write handshake");
        end
        wdata <= ~data; // Second write offered while the response is held
        stall = $urandom_range(3, 0);
        repeat (stall) @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!bvalid && t < 100);
        if (!bvalid) begin
            report_timeout("the write response");
        end
        bready <= 1'b0;
    endtask

    task automatic do_read(addr_t addr);
        int stall;
        int t;
        araddr  <= addr;
        arvalid <= 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!arready && t < 100);
        if (!arready) begin
            report_timeout("the read handshake");
        end
        arvalid <= 1'b0;
        stall = $urandom_range(3, 0);
        repeat (stall) @(posedge clk);
        rready <= 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!rvalid && t < 100);
        if (!rvalid) begin
            report_timeout("the read response");
        end
        rready <= 1'b0;
    endtask

    task automatic press(button_t value);
        buttons <= value;
        repeat (4) @(posedge clk);
        buttons <= '0; // Release
        repeat (4) @(posedge clk);
    endtask

    task automatic wait_tone();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (scoreboard.tone_mode != 0 && t < 300);
        if (scoreboard.tone_mode != 0) begin
            report_timeout("the pwm measurement");
        end
        @(posedge clk);
    endtask

    initial begin
        string line;
        string name;
        string op;
        int    fd;
        int    n;
        int    i;
        data_t arg;
        data_t data;
        data_t expected;
        data_t resp;
        void'($urandom(99));
        reset    = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = 4'hF;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        buttons  = '0;
        switches = 2'b10;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        fd = $fopen("tests/io_cases.txt", "r");
        if (fd == 0) begin
            run_errors++;
            $display("Could not open tests/io_cases.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %h %h %h %h", name, op, arg, data, expected, resp);
            if (n != 6) begin
                run_errors++;
                $display("Malformed line in the cases file: %s", line);
                continue;
            end
            case (op)
                "write": begin
                    scoreboard.expect_write(name, resp_t'(resp));
                    do_write(addr_t'(arg), data);
                end
                "read": begin
                    scoreboard.expect_read(name, expected, resp_t'(resp), 1'b0);
                    do_read(addr_t'(arg));
                end
                "count": begin
                    scoreboard.expect_read(name, '0, RESP_OKAY, 1'b1);
                    do_read(addr_t'(arg));
                end
                "press": begin
                    for (i = 0; i < data; i++) begin
                        press(button_t'((arg - 1 + i) % 7 + 1)); // Cycles through 1 to 7
                    end
                end
                "tone": begin
                    scoreboard.start_tone(name, int'(expected));
                    wait_tone();
                end
                default: begin
                    run_errors++;
                    $display("Unknown operation %s in %s", op, name);
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        @(negedge clk);
        $display("Errors: %0d wrong values, %0d other failures", scoreboard.value_errors,
                 scoreboard.other_errors + run_errors);
        if (scoreboard.value_errors + scoreboard.other_errors + run_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/io_cases.txt
# name op addr_or_button wdata expected resp (all values hex)
# ops: write, read, count (cycle counter read), press (wdata = presses), tone (0 = stays low)
led_a          write 00 0000002a 0 0
led_a_rd       read  00 0 0000002a 0
count_clear    write 10 0 0 0
led_b          write 00 ffffffc5 0 0
led_b_rd       read  00 0 00000005 0
count_rd       count 10 0 0 0
switch_rd      read  1c 0 00000002 0
unmapped_rd    read  20 0 00000000 2
unmapped_wr    write 24 12345678 0 2
readonly_wr    write 1c 00000003 0 2
status_empty   read  14 0 00000001 0
btn_a          press 5 1 0 0
btn_b          press 3 1 0 0
btn_a_rd       read  18 0 00000005 0
btn_b_rd       read  18 0 00000003 0
status_drained read  14 0 00000001 0
btn_fill       press 1 a 0 0
fill_rd_0      read  18 0 00000001 0
fill_rd_1      read  18 0 00000002 0
fill_rd_2      read  18 0 00000003 0
fill_rd_3      read  18 0 00000004 0
fill_rd_4      read  18 0 00000005 0
fill_rd_5      read  18 0 00000006 0
fill_rd_6      read  18 0 00000007 0
fill_rd_7      read  18 0 00000001 0
fill_status    read  14 0 00000001 0
tone_period    write 08 00000005 0 0
tone_period_rd read  08 0 00000005 0
tone_on        write 04 00000001 0 0
tone_run       tone  0 0 5 0
tone_off       write 04 00000000 0 0
tone_quiet     tone  0 0 0 0

//--- filelist.f
hdl/io_pkg.sv
hdl/tone_generator.sv
hdl/button_fifo.sv
hdl/io_regs.sv
hdl/io_top.sv
tests/io_assertions.sv
tests/io_checker.sv
tests/io_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module io_top_tb -f filelist.f -o io_sim
output=$(./obj_dir/io_sim 2>&1) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -q "Simulation finished: PASS"
